//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module aimbot_top -f list.f

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_aimbot -f list.f -o sim_aimbot
	./obj_dir/sim_aimbot | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir

//--- aimbot_cases.txt
// Columns: op (1 hex digit), arg (1 hex digit), data (4 hex digits)
// Ops 1 write reg, 2 read reg expect data, 3 pixel on cam arg, 4 vsync, 5 wait, 6 end test, 7 burst
410000
31F800
3107E0
31001F
710005
500004
100001
500014
100000
500050
600001
100002
710004
420000
720008
500004
100003
500014
100002
500050
600002
420000
720010
500004
100003
500096
100002
500050
600003
420000
720008
500004
11ABCD
100007
500014
100006
500050
100003
500014
100002
500050
600004
220002
120002
220000
420000
720002
500004
100003
500014
100002
500050
220002
120002
220000
600005
420000
720012
500004
220001
100003
500014
100002
500050
220003
120003
220000
600006

//--- aimbot_checker.sv
`timescale 1ns/1ps
`include "aimbot_macros.svh"

module aimbot_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  aimbot_pkg::cam_byte_t cam1,
    input  aimbot_pkg::cam_byte_t cam2,
    input  aimbot_pkg::cfg_req_t  cfg,
    input  logic [15:0]           cfg_rdata,
    input  aimbot_pkg::video_t    video,
    input  logic                  rd_check,
    input  logic [15:0]           rd_expect,
    input  logic                  test_done,
    input  int                    test_id,
    input  logic                  final_req,
    output int                    errors
);

    logic [15:0] exp_q[$];      // Pixels the selected camera got into the buffer
    int          credits[2];
    logic        phase[2];
    logic [7:0]  hi[2];
    logic        cam_sel;
    logic        pattern_en;
    logic [15:0] pattern_color;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          de_run;
    int          hs_run;
    int          lines_in_frame;
    int          hs_rises;
    logic        de_prev;
    logic        hs_prev;
    logic        vs_prev;

    // Top bits of each field copied into the low bits
    function automatic logic [23:0] to_rgb888(input logic [15:0] p);
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
        r = p[15:11];
        g = p[10:5];
        b = p[4:0];
        return {r, r[4:2], g, g[5:4], b, b[4:2]};
    endfunction

    task automatic mismatch(input string name, input logic [23:0] exp, input logic [23:0] got);
        $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
        errors++;
        test_errors++;
    endtask

    task automatic problem(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic watch_camera(input int idx, input aimbot_pkg::cam_byte_t c);
        if (!c.href) begin
            phase[idx] = 1'b0;
        end else if (c.valid) begin
            if (!phase[idx]) begin
                hi[idx] = c.data;
            end else if (credits[idx] > 0) begin
                credits[idx]--;
                if (cam_sel == idx[0]) exp_q.push_back({hi[idx], c.data});
            end
            phase[idx] = !phase[idx];
        end
    endtask

    task automatic check_video;
        logic [23:0] expected;
        expected = 24'h0;
        if (video.de) begin
            if (pattern_en) begin
                expected = to_rgb888(pattern_color);
            end else if (exp_q.size() > 0) begin
                expected = to_rgb888(exp_q.pop_front());
                if (credits[cam_sel] < `AIM_BUF_DEPTH) credits[cam_sel]++;
            end
            if ({video.red, video.green, video.blue} !== expected)
                mismatch("video.rgb", expected, {video.red, video.green, video.blue});
            if (!de_prev) begin
                if (lines_in_frame > 0 && hs_rises != 1)
                    problem($sformatf("%0d hsync pulses between active lines", hs_rises));
                if (lines_in_frame == `AIM_V_ACTIVE)
                    problem("active line started with no vsync after the last frame");
                hs_rises = 0;
                lines_in_frame++;
            end
            de_run++;
        end else if (de_prev) begin
            if (de_run != `AIM_H_ACTIVE)
                problem($sformatf("line had %0d de cycles", de_run));
            de_run = 0;
        end
        if (video.hsync) begin
            if (!hs_prev) hs_rises++;
            hs_run++;
        end else if (hs_prev) begin
            if (hs_run != `AIM_HSYNC_LEN) problem($sformatf("hsync lasted %0d cycles", hs_run));
            hs_run = 0;
        end
        if (video.vsync && !vs_prev) begin
            if (lines_in_frame != `AIM_V_ACTIVE)
                problem($sformatf("frame had %0d active lines", lines_in_frame));
            lines_in_frame = 0;
        end
        de_prev = video.de;
        hs_prev = video.hsync;
        vs_prev = video.vsync;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            credits = '{`AIM_BUF_DEPTH, `AIM_BUF_DEPTH};
            phase = '{1'b0, 1'b0};
            cam_sel = 1'b0;
            pattern_en = 1'b0;
            pattern_color = '0;
            {de_run, hs_run, lines_in_frame, hs_rises} = '0;
            {de_prev, hs_prev, vs_prev} = '0;
        end else begin
            watch_camera(0, cam1);
            watch_camera(1, cam2);
            if (cfg.wr && cfg.addr == 2'(`AIM_REG_CTRL)) begin
                cam_sel = cfg.wdata[1];
                pattern_en = cfg.wdata[2];
            end
            if (cfg.wr && cfg.addr == 2'(`AIM_REG_COLOR)) pattern_color = cfg.wdata;
            if (rd_check && cfg_rdata !== rd_expect) mismatch("cfg_rdata", rd_expect, cfg_rdata);
            check_video();
            if (test_done) begin
                $display("test %0d %s, %0d errors", test_id,
                         test_errors == 0 ? "ok" : "FAILED", test_errors);
                tests_run++;
                if (test_errors != 0) tests_failed++;
                test_errors = 0;
            end
            if (final_req) begin
                if (exp_q.size() != 0) problem($sformatf("%0d pixels never shown", exp_q.size()));
                if (lines_in_frame != 0)
                    problem("last frame ended with no vsync");
                $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
            end
        end
    end

    initial errors = 0;

endmodule

//--- aimbot_macros.svh
`ifndef AIMBOT_MACROS_SVH
`define AIMBOT_MACROS_SVH

// Line buffer depth and the credit count each packer starts with
`define AIM_BUF_DEPTH 16

// Raster in pixels per line and lines per frame
`define AIM_H_ACTIVE    8
`define AIM_H_TOTAL     12
`define AIM_HSYNC_START 9
`define AIM_HSYNC_LEN   2
`define AIM_V_ACTIVE    4
`define AIM_V_TOTAL     6
`define AIM_VSYNC_LINE  5

// Register map
`define AIM_REG_CTRL   0
`define AIM_REG_COLOR  1
`define AIM_REG_STATUS 2

// One full frame of extra cycles past the stimulus
`define AIM_TIMEOUT_MARGIN (`AIM_H_TOTAL * `AIM_V_TOTAL)

`endif

//--- aimbot_pkg.sv
package aimbot_pkg;

    typedef struct packed {
        logic       valid;   // Stands in for the camera pixel clock
        logic       vsync;
        logic       href;
        logic [7:0] data;
    } cam_byte_t;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } pix_bytes_t;

    // Packer writes bytes, display reads colour fields
    typedef union packed {
        rgb565_t    rgb;
        pix_bytes_t bytes;
    } pix_word_u;

    typedef struct packed {
        logic      valid;
        logic      sof;      // First pixel after vsync
        pix_word_u word;
    } pix_t;

    typedef struct packed {
        logic        wr;
        logic [1:0]  addr;
        logic [15:0] wdata;
    } cfg_req_t;

    typedef struct packed {
        logic      disp_en;
        logic      cam_sel;  // 0 picks camera 1
        logic      pattern_en;
        pix_word_u pattern_color;
    } ctrl_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       de;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } video_t;

endpackage

//--- aimbot_top.sv
`timescale 1ns/1ps

module aimbot_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  aimbot_pkg::cam_byte_t cam1,
    input  aimbot_pkg::cam_byte_t cam2,
    input  aimbot_pkg::cfg_req_t  cfg,
    output logic [15:0]          cfg_rdata,
    output aimbot_pkg::video_t   video
);

    aimbot_pkg::pix_t  pix1;
    aimbot_pkg::pix_t  pix2;
    aimbot_pkg::pix_t  head;
    aimbot_pkg::ctrl_t ctrl;
    logic              credit1;
    logic              credit2;
    logic              drop1;
    logic              drop2;
    logic              not_empty;
    logic              pop;
    logic              underflow;

    cam_byte_packer u_cam1_packer (
        .clk       (clk    ),
        .rst_n     (rst_n  ),
        .cam       (cam1   ),
        .credit_ret(credit1),
        .pix       (pix1   ),
        .drop      (drop1  )
    );

    cam_byte_packer u_cam2_packer (
        .clk       (clk    ),
        .rst_n     (rst_n  ),
        .cam       (cam2   ),
        .credit_ret(credit2),
        .pix       (pix2   ),
        .drop      (drop2  )
    );

    pixel_line_buffer u_line_buffer (
        .clk      (clk         ),
        .rst_n    (rst_n       ),
        .cam_sel  (ctrl.cam_sel),
        .pix_a    (pix1        ),
        .pix_b    (pix2        ),
        .pop      (pop         ),
        .head     (head        ),
        .not_empty(not_empty   ),
        .credit_a (credit1     ),
        .credit_b (credit2     )
    );

    disp_timing u_disp_timing (
        .clk      (clk      ),
        .rst_n    (rst_n    ),
        .ctrl     (ctrl     ),
        .head     (head     ),
        .not_empty(not_empty),
        .pop      (pop      ),
        .underflow(underflow),
        .video    (video    )
    );

    view_config u_view_config (
        .clk      (clk      ),
        .rst_n    (rst_n    ),
        .cfg      (cfg      ),
        .drop_a   (drop1    ),
        .drop_b   (drop2    ),
        .underflow(underflow),
        .ctrl     (ctrl     ),
        .rdata    (cfg_rdata)
    );

endmodule

//--- cam_byte_packer.sv
`timescale 1ns/1ps
`include "aimbot_macros.svh"

module cam_byte_packer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  aimbot_pkg::cam_byte_t cam,
    input  logic                  credit_ret,
    output aimbot_pkg::pix_t      pix,
    output logic                  drop
);

    localparam int CW = $clog2(`AIM_BUF_DEPTH + 1);

    logic                  phase;      // High when the high byte is held
    logic                  sof_pend;
    logic [7:0]            hi_byte;
    logic [CW-1:0]         credits;
    logic                  byte_en;
    logic                  pair_done;
    logic                  emit;
    logic                  out_valid;
    logic                  out_sof;
    aimbot_pkg::pix_word_u out_word;

    assign byte_en   = cam.valid && cam.href;
    assign pair_done = byte_en && phase;
    assign emit      = pair_done && (credits != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= 1'b0;
            sof_pend  <= 1'b0;
            credits   <= CW'(`AIM_BUF_DEPTH);
            out_valid <= 1'b0;
            out_sof   <= 1'b0;
            drop      <= 1'b0;
        end else begin
            if (!cam.href) begin
                phase <= 1'b0;            // Next line opens on a high byte
            end else if (byte_en) begin
                phase <= !phase;
            end

            if (cam.vsync) begin
                sof_pend <= 1'b1;
            end else if (emit) begin
                sof_pend <= 1'b0;
            end

            if (credit_ret && !emit && credits != CW'(`AIM_BUF_DEPTH)) begin
                credits <= credits + 1'b1;
            end else if (emit && !credit_ret) begin
                credits <= credits - 1'b1;
            end

            out_valid <= emit;
            out_sof   <= emit && sof_pend;
            drop      <= pair_done && (credits == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (byte_en && !phase) begin
            hi_byte <= cam.data;
        end
        if (pair_done) begin
            out_word.bytes <= '{hi: hi_byte, lo: cam.data};
        end
    end

    assign pix = '{valid: out_valid, sof: out_sof, word: out_word};

    // A wrap below zero would leave the count above the depth
    a_credits_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        credits <= CW'(`AIM_BUF_DEPTH)
    );

endmodule

//--- disp_timing.sv
`timescale 1ns/1ps
`include "aimbot_macros.svh"

module disp_timing (
    input  logic               clk,
    input  logic               rst_n,
    input  aimbot_pkg::ctrl_t  ctrl,
    input  aimbot_pkg::pix_t   head,
    input  logic               not_empty,
    output logic               pop,
    output logic               underflow,
    output aimbot_pkg::video_t video
);

    localparam int HW = $clog2(`AIM_H_TOTAL);
    localparam int VW = $clog2(`AIM_V_TOTAL);

    logic          running;
    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic          line_end;
    logic          frame_end;
    logic          start;
    logic          active;
    logic          hsync_d;
    logic          vsync_d;
    logic [23:0]   rgb_d;
    logic          hsync_q;
    logic          vsync_q;
    logic          de_q;
    logic [23:0]   rgb_q;

    // Top bits of each field refill the low bits
    function automatic logic [23:0] expand565(input aimbot_pkg::pix_word_u w);
        return {w.rgb.red, w.rgb.red[4:2],
                w.rgb.green, w.rgb.green[5:4],
                w.rgb.blue, w.rgb.blue[4:2]};
    endfunction

    assign line_end  = h_cnt == HW'(`AIM_H_TOTAL - 1);
    assign frame_end = line_end && (v_cnt == VW'(`AIM_V_TOTAL - 1));
    assign start     = !running && ctrl.disp_en && not_empty && head.sof;
    assign active    = running && (h_cnt < HW'(`AIM_H_ACTIVE))
                       && (v_cnt < VW'(`AIM_V_ACTIVE));

    // Before a frame, stale pixels ahead of the frame start are thrown away
    assign pop = (active && !ctrl.pattern_en && not_empty)
                 || (!running && ctrl.disp_en && not_empty && !head.sof);
    assign underflow = active && !ctrl.pattern_en && !not_empty;

    assign hsync_d = running && (h_cnt >= HW'(`AIM_HSYNC_START))
                     && (h_cnt < HW'(`AIM_HSYNC_START + `AIM_HSYNC_LEN));
    assign vsync_d = running && (v_cnt == VW'(`AIM_VSYNC_LINE));

    always_comb begin
        if (!active) begin
            rgb_d = '0;
        end else if (ctrl.pattern_en) begin
            rgb_d = expand565(ctrl.pattern_color);
        end else if (not_empty) begin
            rgb_d = expand565(head.word);
        end else begin
            rgb_d = '0;                   // Starved line shows black
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end else if (start) begin
            running <= 1'b1;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end else if (running) begin
            if (line_end) begin
                h_cnt <= '0;
                v_cnt <= frame_end ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
            if (frame_end && !ctrl.disp_en) begin
                running <= 1'b0;          // Finish the frame, then idle
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
            de_q    <= 1'b0;
        end else begin
            hsync_q <= hsync_d;
            vsync_q <= vsync_d;
            de_q    <= active;
        end
    end

    always_ff @(posedge clk) begin
        rgb_q <= rgb_d;
    end

    assign video = '{hsync: hsync_q, vsync: vsync_q, de: de_q,
                     red: rgb_q[23:16], green: rgb_q[15:8], blue: rgb_q[7:0]};

    a_hsync_width: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(video.hsync) |-> video.hsync [*`AIM_HSYNC_LEN] ##1 !video.hsync
    );

endmodule

//--- list.f
+incdir+.
aimbot_pkg.sv
cam_byte_packer.sv
pixel_line_buffer.sv
disp_timing.sv
view_config.sv
aimbot_top.sv
aimbot_checker.sv
tb_aimbot.sv

//--- pixel_line_buffer.sv
`timescale 1ns/1ps
`include "aimbot_macros.svh"

module pixel_line_buffer (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cam_sel,
    input  aimbot_pkg::pix_t pix_a,
    input  aimbot_pkg::pix_t pix_b,
    input  logic             pop,
    output aimbot_pkg::pix_t head,
    output logic             not_empty,
    output logic             credit_a,
    output logic             credit_b
);

    localparam int AW = $clog2(`AIM_BUF_DEPTH);
    localparam int LW = $clog2(`AIM_BUF_DEPTH + 1);

    aimbot_pkg::pix_t mem [`AIM_BUF_DEPTH];
    aimbot_pkg::pix_t wr_pix;
    aimbot_pkg::pix_t head_entry;
    logic [AW-1:0]    wptr;
    logic [AW-1:0]    rptr;
    logic [LW-1:0]    level;
    logic             wr;

    assign wr_pix = cam_sel ? pix_b : pix_a;  // Unselected camera is ignored
    assign wr     = wr_pix.valid;

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wptr] <= wr_pix;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr     <= '0;
            rptr     <= '0;
            level    <= '0;
            credit_a <= 1'b0;
            credit_b <= 1'b0;
        end else begin
            if (wr) begin
                wptr <= wptr + 1'b1;
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
            if (wr && !pop) begin
                level <= level + 1'b1;
            end else if (pop && !wr) begin
                level <= level - 1'b1;
            end
            credit_a <= pop && !cam_sel;
            credit_b <= pop && cam_sel;
        end
    end

    assign not_empty  = level != '0;
    assign head_entry = mem[rptr];
    assign head       = '{valid: not_empty, sof: head_entry.sof, word: head_entry.word};

    // Packers hold back on credits, so the buffer never fills past depth
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr |-> (level != LW'(`AIM_BUF_DEPTH)) || pop
    );

    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> not_empty
    );

endmodule

//--- tb_aimbot.sv
`timescale 1ns/1ps
`include "aimbot_macros.svh"

module tb_aimbot;

    localparam int MAX_CASES = 96;

    logic                  clk;
    logic                  rst_n;
    aimbot_pkg::cam_byte_t cam1;
    aimbot_pkg::cam_byte_t cam2;
    aimbot_pkg::cfg_req_t  cfg;
    logic [15:0]           cfg_rdata;
    aimbot_pkg::video_t    video;
    logic                  rd_check;
    logic [15:0]           rd_expect;
    logic                  test_done;
    int                    test_id;
    logic                  final_req;
    int                    errors;
    logic                  bad_case;
    logic [23:0]           cases [MAX_CASES];
    logic [15:0]           lfsr;
    int                    cycles = 0;
    int                    limit = 1000000;

    aimbot_top aimbot_top_inst (
        .clk      (clk      ),
        .rst_n    (rst_n    ),
        .cam1     (cam1     ),
        .cam2     (cam2     ),
        .cfg      (cfg      ),
        .cfg_rdata(cfg_rdata),
        .video    (video    )
    );

    aimbot_checker u_checker (
        .clk      (clk      ),
        .rst_n    (rst_n    ),
        .cam1     (cam1     ),
        .cam2     (cam2     ),
        .cfg      (cfg      ),
        .cfg_rdata(cfg_rdata),
        .video    (video    ),
        .rd_check (rd_check ),
        .rd_expect(rd_expect),
        .test_done(test_done),
        .test_id  (test_id  ),
        .final_req(final_req),
        .errors   (errors   )
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: stimulus did not finish within %0d cycles", limit);
            $display("Verification failed");
            $finish;
        end
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic step;
        @(posedge clk);
        #1;
    endtask

    task automatic go_idle;
        cam1 = '0;
        cam2 = '0;
        cfg = '0;
        rd_check = 1'b0;
        test_done = 1'b0;
    endtask

    task automatic set_cam(input logic [3:0] idx, input aimbot_pkg::cam_byte_t value);
        if (idx == 4'd1) cam1 = value;
        else cam2 = value;
    endtask

    task automatic send_pair(input logic [3:0] idx, input logic [15:0] p);
        set_cam(idx, '{valid: 1'b1, vsync: 1'b0, href: 1'b1, data: p[15:8]});
        step();
        set_cam(idx, '{valid: 1'b1, vsync: 1'b0, href: 1'b1, data: p[7:0]});
        step();
        set_cam(idx, '0);
    endtask

    task automatic random_pixel(output logic [15:0] p);
        p = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_next(lfsr);
            p = {p[14:0], lfsr[0]};
        end
    endtask

    task automatic run_case(input logic [23:0] w);
        logic [15:0] p;
        case (w[23:20])
            4'h1: begin
                cfg = '{wr: 1'b1, addr: w[17:16], wdata: w[15:0]};
                step();
            end
            4'h2: begin
                cfg = '{wr: 1'b0, addr: w[17:16], wdata: 16'h0};
                rd_check = 1'b1;
                rd_expect = w[15:0];
                step();
            end
            4'h3: send_pair(w[19:16], w[15:0]);
            4'h4: begin
                set_cam(w[19:16], '{valid: 1'b0, vsync: 1'b1, href: 1'b0, data: 8'h0});
                step();
            end
            4'h5: repeat (int'(w[15:0])) step();
            4'h6: begin
                test_id = int'(w[15:0]);
                test_done = 1'b1;
                step();
            end
            4'h7: begin
                repeat (int'(w[15:0])) begin
                    random_pixel(p);
                    send_pair(w[19:16], p);
                end
            end
            default: begin
                $display("Unknown command %h in the case file", w);
                bad_case = 1'b1;
            end
        endcase
        go_idle();
    endtask

    initial begin
        int total;
        clk = 1'b0;
        rst_n = 1'b0;
        go_idle();
        final_req = 1'b0;
        rd_expect = '0;
        test_id = 0;
        bad_case = 1'b0;
        lfsr = 16'd18671;
        total = 0;
        foreach (cases[i]) cases[i] = '0;
        $readmemh("aimbot_cases.txt", cases);
        for (int i = 0; i < MAX_CASES; i++) begin
            if (cases[i][23:20] == 4'h0) break;
            case (cases[i][23:20])
                4'h5: total += int'(cases[i][15:0]);
                4'h7: total += 2 * int'(cases[i][15:0]);
                default: total += 2;
            endcase
        end
        limit = 10 + total + MAX_CASES + `AIM_TIMEOUT_MARGIN;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < MAX_CASES; i++) begin
            if (cases[i][23:20] == 4'h0) break;
            run_case(cases[i]);
        end
        final_req = 1'b1;
        step();
        final_req = 1'b0;
        step();
        if (errors == 0 && !bad_case) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- view_config.sv
`timescale 1ns/1ps
`include "aimbot_macros.svh"

module view_config (
    input  logic                 clk,
    input  logic                 rst_n,
    input  aimbot_pkg::cfg_req_t cfg,
    input  logic                 drop_a,
    input  logic                 drop_b,
    input  logic                 underflow,
    output aimbot_pkg::ctrl_t    ctrl,
    output logic [15:0]          rdata
);

    logic                  disp_en;
    logic                  cam_sel;
    logic                  pattern_en;
    aimbot_pkg::pix_word_u color;
    logic                  ovf;
    logic                  udf;
    logic                  wr_ctrl;
    logic                  wr_color;
    logic                  wr_status;

    assign wr_ctrl   = cfg.wr && (cfg.addr == 2'(`AIM_REG_CTRL));
    assign wr_color  = cfg.wr && (cfg.addr == 2'(`AIM_REG_COLOR));
    assign wr_status = cfg.wr && (cfg.addr == 2'(`AIM_REG_STATUS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            disp_en    <= 1'b0;
            cam_sel    <= 1'b0;
            pattern_en <= 1'b0;
            color      <= '0;
            ovf        <= 1'b0;
            udf        <= 1'b0;
        end else begin
            if (wr_ctrl) begin
                disp_en    <= cfg.wdata[0];
                cam_sel    <= cfg.wdata[1];
                pattern_en <= cfg.wdata[2];
            end
            if (wr_color) begin
                color <= cfg.wdata;
            end
            // New events win over a clear in the same cycle
            ovf <= drop_a || drop_b || (ovf && !(wr_status && cfg.wdata[0]));
            udf <= underflow || (udf && !(wr_status && cfg.wdata[1]));
        end
    end

    assign ctrl = '{disp_en: disp_en, cam_sel: cam_sel, pattern_en: pattern_en,
                    pattern_color: color};

    always_comb begin
        case (cfg.addr)
            2'(`AIM_REG_CTRL):   rdata = {13'd0, pattern_en, cam_sel, disp_en};
            2'(`AIM_REG_COLOR):  rdata = color;
            2'(`AIM_REG_STATUS): rdata = {14'd0, udf, ovf};
            default:             rdata = '0;
        endcase
    end

endmodule
